// File: test/lc3b_exec_trace.txt
# I <instr hex> strobes after a random gap, B <instr hex> strobes with no gap
# E <dest> <data hex> <cc nzp binary> is the next writeback in order
I 1225
E 1 0005 001
I 147D
E 2 0002 001
I 1642
E 3 0007 001
I 98FF
E 4 fff8 100
I 5B03
E 5 0000 010
I 5D2F
E 6 0008 001
I 0E02
I 7782
I 79BF
I 6B82
E 5 0007 001
B 65BF
E 2 fff8 100
B 6782
E 3 0007 001
B 69BF
E 4 fff8 100
B 6182
E 0 0007 001
B 63BF
E 1 fff8 100
B 6F82
E 7 0007 001
B 6DBF
E 6 fff8 100
B 1B40
E 5 000e 001
I 9B7F
E 5 fff1 100
I 1B6F
E 5 0000 010
I 0E02
I F025

// File: list.f
hdl/lc3b_isa_pkg.sv
hdl/lc3b_ctrl_pkg.sv
hdl/control_rom.sv
hdl/decoded_instr_fifo.sv
hdl/execute_unit.sv
hdl/lc3b_exec_top.sv
test/lc3b_exec_chk.sv
test/tb_lc3b_exec.sv

// File: Bender.yml
package:
  name: lc3b_exec

sources:
  - hdl/lc3b_isa_pkg.sv
  - hdl/lc3b_ctrl_pkg.sv
  - hdl/control_rom.sv
  - hdl/decoded_instr_fifo.sv
  - hdl/execute_unit.sv
  - hdl/lc3b_exec_top.sv
  - target: test
    files:
      - test/lc3b_exec_chk.sv
      - test/tb_lc3b_exec.sv

// File: test/tb_lc3b_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc3b_exec;

    logic                               clk;
    logic                               reset;
    logic                               instr_valid;
    logic [lc3b_isa_pkg::word_w-1:0]    instr;
    logic                               full;
    logic                               wb_valid;
    logic [lc3b_isa_pkg::reg_idx_w-1:0] wb_dest;
    logic [lc3b_isa_pkg::word_w-1:0]    wb_data;
    logic [2:0]                         cc;

    logic [lc3b_isa_pkg::word_w-1:0]    instr_q [$];
    bit                                 burst_q [$];  // strobe with no idle gap
    logic [lc3b_isa_pkg::reg_idx_w-1:0] exp_dest_q [$];
    logic [lc3b_isa_pkg::word_w-1:0]    exp_data_q [$];
    logic [2:0]                         exp_cc_q [$];
    logic [2:0]                         last_cc;
    logic                               full_seen;
    logic [31:0]                        seed;
    int                                 trace_lines;
    int                                 cycle_limit;
    int                                 cycles;
    int                                 mismatch_errors;
    int                                 other_errors;

    lc3b_exec_top DUT (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .full        (full),
        .wb_valid    (wb_valid),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data),
        .cc          (cc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] step_lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_wb(input logic [lc3b_isa_pkg::reg_idx_w-1:0] got_dest,
                            input logic [lc3b_isa_pkg::word_w-1:0] got_data,
                            input logic [lc3b_isa_pkg::reg_idx_w-1:0] exp_dest,
                            input logic [lc3b_isa_pkg::word_w-1:0] exp_data);
        if (got_dest !== exp_dest || got_data !== exp_data) begin
            $display("FAIL %0t: writeback r%0d = %h, expected r%0d = %h",
                     $time, got_dest, got_data, exp_dest, exp_data);
            mismatch_errors++;
        end
    endtask

    task automatic check_cc(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: cc = %b, expected %b", $time, got, exp);
            mismatch_errors++;
        end
    endtask

    task automatic load_trace;
        int          fd;
        int          dest;
        string       line;
        string       kind;
        logic [15:0] value;
        logic [2:0]  ccv;
        fd = $fopen("test/lc3b_exec_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file test/lc3b_exec_trace.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%s", kind) != 1)
                continue;  // blank line
            if (kind == "I" || kind == "B") begin
                void'($sscanf(line, "%s %h", kind, value));
                instr_q.push_back(value);
                burst_q.push_back(kind == "B");
                trace_lines++;
            end else if (kind == "E") begin
                void'($sscanf(line, "%s %d %h %b", kind, dest, value, ccv));
                exp_dest_q.push_back(dest[lc3b_isa_pkg::reg_idx_w-1:0]);
                exp_data_q.push_back(value);
                exp_cc_q.push_back(ccv);
                last_cc = ccv;
                trace_lines++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_trace;
        for (int i = 0; i < instr_q.size(); i++) begin
            if (!burst_q[i]) begin
                seed = step_lcg(seed);
                repeat (seed[17:16]) @(negedge clk);  // 0 to 3 idle cycles
            end
            while (full)
                @(negedge clk);
            instr_valid = 1'b1;
            instr       = instr_q[i];
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    // cc is written on the same edge as the writeback registers
    always @(negedge clk) begin
        if (!reset && full)
            full_seen = 1'b1;  // load burst backs up the fifo
        if (!reset && wb_valid) begin
            if (exp_dest_q.size() == 0) begin
                $display("%0t: writeback to r%0d arrived with no expected entry left",
                         $time, wb_dest);
                other_errors++;
            end else begin
                check_wb(wb_dest, wb_data, exp_dest_q.pop_front(), exp_data_q.pop_front());
                check_cc(cc, exp_cc_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d expected writebacks still pending",
                     cycles, exp_dest_q.size());
            $display("errors: %0d value mismatches, %0d other, %0d assertion failures",
                     mismatch_errors, other_errors + 1, DUT.u_chk.fail_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        reset           = 1'b1;
        instr_valid     = 1'b0;
        instr           = '0;
        seed            = 32'hfaef;
        trace_lines     = 0;
        cycle_limit     = 0;
        cycles          = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        full_seen       = 1'b0;
        last_cc         = lc3b_ctrl_pkg::cc_z;
        load_trace();
        cycle_limit = 8 * trace_lines + 50;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        drive_trace();
        while (exp_dest_q.size() != 0)
            @(negedge clk);
        repeat (10) @(negedge clk);  // room for a stray writeback
        check_cc(cc, last_cc);       // trailing br and trap leave cc alone
        if (!full_seen) begin
            $display("full never rose while the back-to-back loads were queued");
            other_errors++;
        end
        $display("errors: %0d value mismatches, %0d other, %0d assertion failures",
                 mismatch_errors, other_errors, DUT.u_chk.fail_count);
        if (mismatch_errors == 0 && other_errors == 0 && DUT.u_chk.fail_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/lc3b_exec_chk.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_exec_chk (
    input logic                            clk,
    input logic                            reset,
    input logic                            instr_valid,
    input logic                            full,
    input logic                            wb_valid,
    input logic [lc3b_isa_pkg::word_w-1:0] wb_data,
    input logic [2:0]                      cc
);

    int fail_count = 0;

    wb_quiet_after_reset: assert property (@(posedge clk) reset |=> !wb_valid)
        else begin $error("wb_valid high during or just after reset"); fail_count++; end

    cc_one_hot: assert property (@(posedge clk) disable iff (reset) $onehot(cc))
        else begin $error("cc is not one-hot"); fail_count++; end

    no_strobe_when_full: assert property (@(posedge clk) disable iff (reset)
                                          instr_valid |-> !full)
        else begin $error("instruction strobe while full"); fail_count++; end

    wb_data_known: assert property (@(posedge clk) disable iff (reset)
                                    wb_valid |-> !$isunknown(wb_data))
        else begin $error("wb_data has unknown bits"); fail_count++; end

endmodule

bind lc3b_exec_top lc3b_exec_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .full        (full),
    .wb_valid    (wb_valid),
    .wb_data     (wb_data),
    .cc          (cc)
);

`default_nettype wire

// File: hdl/lc3b_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_exec_top #(
    parameter int fifo_depth = 4,
    parameter int mem_addr_w = 6
) (
    input  logic clk,
    input  logic reset,
    input  logic instr_valid,
    input  logic [lc3b_isa_pkg::word_w-1:0] instr,
    output logic full,
    output logic wb_valid,
    output logic [lc3b_isa_pkg::reg_idx_w-1:0] wb_dest,
    output logic [lc3b_isa_pkg::word_w-1:0] wb_data,
    output logic [2:0] cc
);

    logic [lc3b_ctrl_pkg::ctrl_w-1:0]                       ctrl;
    logic [lc3b_ctrl_pkg::ctrl_w+lc3b_isa_pkg::word_w-1:0] head_entry;
    logic                                                   fifo_empty;
    logic                                                   fifo_pop;

    control_rom u_rom (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // entry is the decoded fields on top of the raw word
    decoded_instr_fifo #(
        .depth (fifo_depth)
    ) u_fifo (
        .clk     (clk),
        .reset   (reset),
        .push    (instr_valid),
        .wr_data ({ctrl, instr}),
        .pop     (fifo_pop),
        .rd_data (head_entry),
        .empty   (fifo_empty),
        .full    (full)
    );

    execute_unit #(
        .mem_addr_w (mem_addr_w)
    ) u_exec (
        .clk      (clk),
        .reset    (reset),
        .empty    (fifo_empty),
        .rd_data  (head_entry),
        .pop      (fifo_pop),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest),
        .wb_data  (wb_data),
        .cc       (cc)
    );

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit #(
    parameter int mem_addr_w = 6
) (
    input  logic clk,
    input  logic reset,
    input  logic empty,
    input  logic [lc3b_ctrl_pkg::ctrl_w+lc3b_isa_pkg::word_w-1:0] rd_data,
    output logic pop,
    output logic wb_valid,
    output logic [lc3b_isa_pkg::reg_idx_w-1:0] wb_dest,
    output logic [lc3b_isa_pkg::word_w-1:0] wb_data,
    output logic [2:0] cc
);

    localparam int word_w = lc3b_isa_pkg::word_w;
    localparam int idx_w  = lc3b_isa_pkg::reg_idx_w;

    logic [lc3b_ctrl_pkg::ctrl_w-1:0] ctrl;
    lc3b_isa_pkg::lc3b_instr_u        instr;

    logic [word_w-1:0]     regs [2**idx_w];
    logic [word_w-1:0]     dmem [2**mem_addr_w];
    logic                  busy;     // second cycle of ldr
    logic [idx_w-1:0]      ld_dest;
    logic [word_w-1:0]     mem_q;    // registered load data

    logic [1:0]            alu_op;
    logic                  mem_read;
    logic                  mem_write;
    logic [idx_w-1:0]      src2_idx;
    logic [word_w-1:0]     opa;
    logic [word_w-1:0]     src2_val;
    logic [word_w-1:0]     imm_val;
    logic [word_w-1:0]     opb;
    logic [word_w-1:0]     alu_result;
    logic [mem_addr_w-1:0] mem_addr;
    logic                  alu_wr;
    logic                  alu_cc;

    function automatic logic [2:0] cc_of(input logic [word_w-1:0] value);
        if (value[word_w-1])
            return lc3b_ctrl_pkg::cc_n;
        else if (value == '0)
            return lc3b_ctrl_pkg::cc_z;
        else
            return lc3b_ctrl_pkg::cc_p;
    endfunction

    assign ctrl  = rd_data[lc3b_ctrl_pkg::ctrl_w+word_w-1:word_w];
    assign instr = rd_data[word_w-1:0];

    assign alu_op    = ctrl[lc3b_ctrl_pkg::ctrl_alu_op_lo +: 2];
    assign mem_read  = ctrl[lc3b_ctrl_pkg::ctrl_mem_read];
    assign mem_write = ctrl[lc3b_ctrl_pkg::ctrl_mem_write];

    // str reads its data register through the dr field
    assign src2_idx = ctrl[lc3b_ctrl_pkg::ctrl_src2_is_dest] ? instr.mem.dr : instr.alu_reg.sr2;
    assign opa      = regs[instr.alu_reg.sr1];
    assign src2_val = regs[src2_idx];
    assign imm_val  = (mem_read | mem_write) ?
                      {{(word_w-7){instr.mem.offset6[5]}}, instr.mem.offset6, 1'b0} :
                      {{(word_w-5){instr.alu_imm.imm5[4]}}, instr.alu_imm.imm5};
    assign opb      = ctrl[lc3b_ctrl_pkg::ctrl_alu_src_imm] ? imm_val : src2_val;

    always_comb begin
        case (alu_op)
            lc3b_ctrl_pkg::alu_add: alu_result = opa + opb;
            lc3b_ctrl_pkg::alu_and: alu_result = opa & opb;
            lc3b_ctrl_pkg::alu_not: alu_result = ~opa;
            default:                alu_result = opa;  // pass
        endcase
    end

    assign mem_addr = alu_result[mem_addr_w:1];  // word address

    assign pop    = ~empty & ~busy;
    assign alu_wr = pop & ctrl[lc3b_ctrl_pkg::ctrl_reg_load] & ~mem_read;
    assign alu_cc = pop & ctrl[lc3b_ctrl_pkg::ctrl_cc_load] & ~mem_read;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            wb_valid <= 1'b0;
            cc       <= lc3b_ctrl_pkg::cc_z;
            for (int i = 0; i < 2**idx_w; i++)
                regs[i] <= '0;
        end else begin
            wb_valid <= alu_wr | busy;
            if (busy) begin
                busy          <= 1'b0;  // load completes
                regs[ld_dest] <= mem_q;
                cc            <= cc_of(mem_q);
            end else begin
                busy <= pop & mem_read;
                if (alu_wr)
                    regs[instr.alu_reg.dr] <= alu_result;
                if (alu_cc)
                    cc <= cc_of(alu_result);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop & mem_write)
            dmem[mem_addr] <= src2_val;
        if (pop & mem_read) begin
            mem_q   <= dmem[mem_addr];
            ld_dest <= instr.mem.dr;
        end
        if (busy) begin
            wb_dest <= ld_dest;
            wb_data <= mem_q;
        end else if (alu_wr) begin
            wb_dest <= instr.alu_reg.dr;
            wb_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/decoded_instr_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module decoded_instr_fifo #(
    parameter int depth = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic push,
    input  logic [lc3b_ctrl_pkg::ctrl_w+lc3b_isa_pkg::word_w-1:0] wr_data,
    input  logic pop,
    output logic [lc3b_ctrl_pkg::ctrl_w+lc3b_isa_pkg::word_w-1:0] rd_data,
    output logic empty,
    output logic full
);

    localparam int entry_w = lc3b_ctrl_pkg::ctrl_w + lc3b_isa_pkg::word_w;
    localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w   = $clog2(depth + 1);

    logic [entry_w-1:0] entries [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic [cnt_w-1:0]   count_next;
    logic               do_push;
    logic               do_pop;

    assign do_pop     = pop & ~empty;
    assign do_push    = push & (~full | do_pop);  // full is fine if head leaves too
    assign count_next = count + cnt_w'(do_push) - cnt_w'(do_pop);
    assign rd_data    = entries[rd_ptr];          // head entry

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count_next;
            empty <= (count_next == '0);
            full  <= (count_next == cnt_w'(depth));
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            entries[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

// File: hdl/control_rom.sv
`timescale 1ns/1ps
`default_nettype none

module control_rom (
    input  lc3b_isa_pkg::lc3b_instr_u         instr,
    output logic [lc3b_ctrl_pkg::ctrl_w-1:0]  ctrl
);

    always_comb begin
        // defaults, no operation
        ctrl = '0;
        ctrl[lc3b_ctrl_pkg::ctrl_alu_op_lo +: 2]  = lc3b_ctrl_pkg::alu_pass;
        ctrl[lc3b_ctrl_pkg::ctrl_alu_src_imm]     = 1'b0;
        ctrl[lc3b_ctrl_pkg::ctrl_cc_load]         = 1'b0;
        ctrl[lc3b_ctrl_pkg::ctrl_mem_read]        = 1'b0;
        ctrl[lc3b_ctrl_pkg::ctrl_mem_write]       = 1'b0;
        ctrl[lc3b_ctrl_pkg::ctrl_reg_load]        = 1'b0;
        ctrl[lc3b_ctrl_pkg::ctrl_src2_is_dest]    = 1'b0;

        case (instr.alu_reg.opcode)
            lc3b_isa_pkg::op_add: begin
                ctrl[lc3b_ctrl_pkg::ctrl_alu_op_lo +: 2] = lc3b_ctrl_pkg::alu_add;
                ctrl[lc3b_ctrl_pkg::ctrl_alu_src_imm]    = instr.alu_reg.imm;  // sr2 or imm5
                ctrl[lc3b_ctrl_pkg::ctrl_cc_load]        = 1'b1;
                ctrl[lc3b_ctrl_pkg::ctrl_reg_load]       = 1'b1;
            end

            lc3b_isa_pkg::op_and: begin
                ctrl[lc3b_ctrl_pkg::ctrl_alu_op_lo +: 2] = lc3b_ctrl_pkg::alu_and;
                ctrl[lc3b_ctrl_pkg::ctrl_alu_src_imm]    = instr.alu_reg.imm;
                ctrl[lc3b_ctrl_pkg::ctrl_cc_load]        = 1'b1;
                ctrl[lc3b_ctrl_pkg::ctrl_reg_load]       = 1'b1;
            end

            lc3b_isa_pkg::op_not: begin
                ctrl[lc3b_ctrl_pkg::ctrl_alu_op_lo +: 2] = lc3b_ctrl_pkg::alu_not;
                ctrl[lc3b_ctrl_pkg::ctrl_cc_load]        = 1'b1;
                ctrl[lc3b_ctrl_pkg::ctrl_reg_load]       = 1'b1;
            end

            lc3b_isa_pkg::op_ldr: begin
                ctrl[lc3b_ctrl_pkg::ctrl_alu_op_lo +: 2] = lc3b_ctrl_pkg::alu_add;  // base + off
                ctrl[lc3b_ctrl_pkg::ctrl_alu_src_imm]    = 1'b1;
                ctrl[lc3b_ctrl_pkg::ctrl_mem_read]       = 1'b1;
                ctrl[lc3b_ctrl_pkg::ctrl_cc_load]        = 1'b1;
                ctrl[lc3b_ctrl_pkg::ctrl_reg_load]       = 1'b1;
            end

            lc3b_isa_pkg::op_str: begin
                ctrl[lc3b_ctrl_pkg::ctrl_alu_op_lo +: 2] = lc3b_ctrl_pkg::alu_add;
                ctrl[lc3b_ctrl_pkg::ctrl_alu_src_imm]    = 1'b1;
                ctrl[lc3b_ctrl_pkg::ctrl_mem_write]      = 1'b1;
                ctrl[lc3b_ctrl_pkg::ctrl_src2_is_dest]   = 1'b1;  // store data from dr field
            end

            lc3b_isa_pkg::op_br: begin
                ctrl = '0;  // no pc here, consumed as a no-op
            end

            default: begin
                ctrl = '0;  // unknown opcode
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/lc3b_ctrl_pkg.sv
`default_nettype none

package lc3b_ctrl_pkg;

    // alu operations
    localparam logic [1:0] alu_pass = 2'd0;
    localparam logic [1:0] alu_add  = 2'd1;
    localparam logic [1:0] alu_and  = 2'd2;
    localparam logic [1:0] alu_not  = 2'd3;

    // bit positions inside the packed control word
    localparam int ctrl_alu_op_lo    = 0;  // two bits
    localparam int ctrl_alu_src_imm  = 2;
    localparam int ctrl_cc_load      = 3;
    localparam int ctrl_mem_read     = 4;
    localparam int ctrl_mem_write    = 5;
    localparam int ctrl_reg_load     = 6;
    localparam int ctrl_src2_is_dest = 7;

    localparam int ctrl_w = 8;

    // condition codes, one-hot nzp
    localparam logic [2:0] cc_n = 3'b100;
    localparam logic [2:0] cc_z = 3'b010;
    localparam logic [2:0] cc_p = 3'b001;

endpackage

`default_nettype wire

// File: hdl/lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

    localparam int word_w    = 16;  // machine word
    localparam int reg_idx_w = 3;   // eight registers

    // opcodes, bits [15:12]
    localparam logic [3:0] op_br  = 4'b0000;
    localparam logic [3:0] op_add = 4'b0001;
    localparam logic [3:0] op_and = 4'b0101;
    localparam logic [3:0] op_ldr = 4'b0110;
    localparam logic [3:0] op_str = 4'b0111;
    localparam logic [3:0] op_not = 4'b1001;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [3:0]           opcode;
            logic [reg_idx_w-1:0] dr;
            logic [reg_idx_w-1:0] sr1;
            logic                 imm;      // 0 here
            logic [1:0]           pad;
            logic [reg_idx_w-1:0] sr2;
        } alu_reg;
        struct packed {
            logic [3:0]           opcode;
            logic [reg_idx_w-1:0] dr;
            logic [reg_idx_w-1:0] sr1;
            logic                 imm;      // 1 here
            logic [4:0]           imm5;
        } alu_imm;
        struct packed {
            logic [3:0]           opcode;
            logic [reg_idx_w-1:0] dr;       // dest for ldr, source for str
            logic [reg_idx_w-1:0] base;
            logic [5:0]           offset6;  // word offset, scaled by two
        } mem;
    } lc3b_instr_u;

endpackage

`default_nettype wire
